/* tb.f */
hdl/arp_pkg.sv
hdl/arp_ifs.sv
hdl/arp_rx_filter.sv
hdl/arp_route_resolve.sv
hdl/arp_lookup_fsm.sv
hdl/arp_cache.sv
hdl/arp_tx_select.sv
hdl/arp_top.sv
verif/arp_tb.sv

/* Bender.yml */
package:
  name: arp_engine

sources:
  - files:
      - hdl/arp_pkg.sv
      - hdl/arp_ifs.sv
      - hdl/arp_rx_filter.sv
      - hdl/arp_route_resolve.sv
      - hdl/arp_lookup_fsm.sv
      - hdl/arp_cache.sv
      - hdl/arp_tx_select.sv
      - hdl/arp_top.sv
  - target: test
    files:
      - verif/arp_tb.sv

/* verif/arp_tb.sv */
// ARP engine testbench
// clock and reset, output frame monitor, directed tests, error counts
`timescale 1ns/100ps

module arp_tb;
    import arp_pkg::*;

    localparam ip_addr_t LOCAL_IP = 32'h0A00_0002;
    localparam ip_addr_t GW_IP    = 32'h0A00_0001;
    localparam ip_addr_t HOST_IP  = 32'h0A00_0007;
    localparam int       MISS_WAIT = RETRY_COUNT * RETRY_INTERVAL + REQUEST_TIMEOUT + 200;

    logic        clk, rst_n, clear_cache;
    logic        in_frame_valid, in_frame_ready, out_frame_valid, out_frame_ready;
    logic        arp_request_valid, arp_request_ready;
    logic        arp_response_valid, arp_response_ready, arp_response_error;
    logic [15:0] in_eth_type, in_arp_htype, in_arp_ptype;
    arp_oper_t   in_arp_oper, out_arp_oper;
    mac_addr_t   in_eth_src_mac, in_arp_sha, in_arp_tha, local_mac;
    mac_addr_t   out_eth_dest_mac, out_arp_tha, arp_response_mac;
    ip_addr_t    in_arp_spa, in_arp_tpa, out_arp_tpa, arp_request_ip;
    ip_addr_t    local_ip, gateway_ip, subnet_mask;

    logic        stall_en;
    int          check_count, mismatch_count, failure_count;
    mac_addr_t   host_mac;
    // frames seen on the output, in order
    mac_addr_t   q_dest[$];
    mac_addr_t   q_tha[$];
    arp_oper_t   q_oper[$];
    ip_addr_t    q_tpa[$];

    arp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && out_frame_valid && out_frame_ready) begin
            q_dest.push_back(out_eth_dest_mac);
            q_oper.push_back(out_arp_oper);
            q_tha.push_back(out_arp_tha);
            q_tpa.push_back(out_arp_tpa);
        end
    end

    function automatic mac_addr_t random_mac();
        return mac_addr_t'({$urandom(), $urandom()});
    endfunction

    task automatic drive_ready_stalls();
        forever begin
            @(posedge clk);
            #1;
            out_frame_ready = stall_en ? ($urandom_range(3) != 0) : 1'b1;
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic confirm(input logic ok, input string what);
        check_count++;
        assert (ok) else begin
            failure_count++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    task automatic send_frame(input mac_addr_t src, input logic [15:0] htype,
                              input arp_oper_t oper, input mac_addr_t sha,
                              input ip_addr_t spa, input ip_addr_t tpa);
        int   n = 0;
        logic done = 1'b0;
        in_frame_valid = 1'b1;
        in_eth_src_mac = src;
        in_arp_htype   = htype;
        in_arp_oper    = oper;
        in_arp_sha     = sha;
        in_arp_spa     = spa;
        in_arp_tpa     = tpa;
        in_arp_tha     = (oper == ARP_OPER_REQUEST) ? '0 : local_mac;
        while (!done && n < 100) begin
            @(posedge clk);
            done = in_frame_ready;
            n++;
        end
        #1;
        in_frame_valid = 1'b0;
        confirm(done, "input frame was never accepted");
    endtask

    task automatic start_lookup(input ip_addr_t ip);
        int   n = 0;
        logic done = 1'b0;
        arp_request_valid = 1'b1;
        arp_request_ip    = ip;
        while (!done && n < 100) begin
            @(posedge clk);
            done = arp_request_ready;
            n++;
        end
        #1;
        arp_request_valid = 1'b0;
        confirm(done, "lookup request was never accepted");
    endtask

    // the MAC only means something when there is no error
    task automatic take_response(input int limit, input logic exp_error,
                                 input mac_addr_t exp_mac);
        int        n = 0;
        logic      seen = 1'b0;
        logic      err;
        mac_addr_t mac;
        while (!seen && n < limit) begin
            @(posedge clk);
            seen = arp_response_valid;
            err  = arp_response_error;
            mac  = arp_response_mac;
            n++;
        end
        #1;
        confirm(seen, "no lookup response arrived");
        if (seen) begin
            compare_value("arp_response_error", err, exp_error);
            if (!exp_error) compare_value("arp_response_mac", mac, exp_mac);
            arp_response_ready = 1'b1;
            @(posedge clk);
            #1;
            arp_response_ready = 1'b0;
        end
    endtask

    task automatic wait_for_frames(input int count, input int limit);
        int n = 0;
        while (q_dest.size() < count && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        confirm(q_dest.size() >= count, "expected output frame did not appear");
    endtask

    task automatic verify_next_frame(input mac_addr_t dest, input arp_oper_t oper,
                                     input mac_addr_t tha, input ip_addr_t tpa);
        if (q_dest.size() == 0) begin
            confirm(1'b0, "no output frame left to compare");
        end else begin
            compare_value("out_eth_dest_mac", q_dest.pop_front(), dest);
            compare_value("out_arp_oper", q_oper.pop_front(), oper);
            compare_value("out_arp_tha", q_tha.pop_front(), tha);
            compare_value("out_arp_tpa", q_tpa.pop_front(), tpa);
        end
    endtask

    task automatic drop_frames();
        q_dest.delete();
        q_oper.delete();
        q_tha.delete();
        q_tpa.delete();
    endtask

    task automatic reply_to_request();
        mac_addr_t src = random_mac();
        mac_addr_t sha = random_mac();
        ip_addr_t  spa = 32'h0A00_0009;
        drop_frames();
        stall_en = 1'b1;
        send_frame(src, ARP_HTYPE_ETH, ARP_OPER_REQUEST, sha, spa, LOCAL_IP);
        wait_for_frames(1, 200);
        repeat (50) @(posedge clk);
        #1;
        stall_en = 1'b0;
        compare_value("reply frame count", q_dest.size(), 1);
        verify_next_frame(src, ARP_OPER_REPLY, sha, spa);
        // request for another host, then a bad htype
        send_frame(random_mac(), ARP_HTYPE_ETH, ARP_OPER_REQUEST, random_mac(),
                   32'h0A00_000A, 32'h0A00_0032);
        send_frame(random_mac(), 16'h0006, ARP_OPER_REQUEST, random_mac(),
                   32'h0A00_000B, LOCAL_IP);
        repeat (50) @(posedge clk);
        #1;
        compare_value("unexpected frame count", q_dest.size(), 0);
    endtask

    task automatic broadcast_lookups();
        start_lookup(IP_BROADCAST);
        take_response(20, 1'b0, MAC_BROADCAST);
        start_lookup(32'h0A00_00FF);
        take_response(20, 1'b0, MAC_BROADCAST);
    endtask

    task automatic learned_hits();
        mac_addr_t gw_mac = random_mac();
        host_mac = random_mac();
        drop_frames();
        send_frame(random_mac(), ARP_HTYPE_ETH, ARP_OPER_REPLY, host_mac, HOST_IP, LOCAL_IP);
        send_frame(random_mac(), ARP_HTYPE_ETH, ARP_OPER_REPLY, gw_mac, GW_IP, LOCAL_IP);
        start_lookup(HOST_IP);
        take_response(20, 1'b0, host_mac);
        // off-subnet, resolved through the gateway
        start_lookup(32'h0808_0808);
        take_response(20, 1'b0, gw_mac);
        compare_value("output frame count", q_dest.size(), 0);
    endtask

    task automatic miss_answered_late();
        ip_addr_t  ip  = 32'h0A00_0014;
        mac_addr_t mac = random_mac();
        drop_frames();
        start_lookup(ip);
        wait_for_frames(1, 100);
        verify_next_frame(MAC_BROADCAST, ARP_OPER_REQUEST, '0, ip);
        send_frame(random_mac(), ARP_HTYPE_ETH, ARP_OPER_REPLY, mac, ip, LOCAL_IP);
        take_response(100, 1'b0, mac);
    endtask

    task automatic miss_never_answered();
        ip_addr_t ip = 32'h0A00_0015;
        drop_frames();
        start_lookup(ip);
        take_response(MISS_WAIT, 1'b1, '0);
        compare_value("request frame count", q_dest.size(), RETRY_COUNT);
        repeat (RETRY_COUNT) verify_next_frame(MAC_BROADCAST, ARP_OPER_REQUEST, '0, ip);
    endtask

    task automatic clear_and_relookup();
        drop_frames();
        clear_cache = 1'b1;
        @(posedge clk);
        #1;
        clear_cache = 1'b0;
        start_lookup(HOST_IP);
        wait_for_frames(1, 100);
        verify_next_frame(MAC_BROADCAST, ARP_OPER_REQUEST, '0, HOST_IP);
        send_frame(random_mac(), ARP_HTYPE_ETH, ARP_OPER_REPLY, host_mac, HOST_IP, LOCAL_IP);
        take_response(100, 1'b0, host_mac);
    endtask

    initial begin
        void'($urandom(66));
        rst_n              = 1'b0;
        stall_en           = 1'b0;
        clear_cache        = 1'b0;
        in_frame_valid     = 1'b0;
        out_frame_ready    = 1'b1;
        arp_request_valid  = 1'b0;
        arp_request_ip     = '0;
        arp_response_ready = 1'b0;
        in_eth_src_mac     = '0;
        in_eth_type        = ETH_TYPE_ARP;
        in_arp_htype       = ARP_HTYPE_ETH;
        in_arp_ptype       = ARP_PTYPE_IPV4;
        in_arp_oper        = ARP_OPER_REQUEST;
        in_arp_sha         = '0;
        in_arp_spa         = '0;
        in_arp_tha         = '0;
        in_arp_tpa         = '0;
        local_mac          = 48'h02_00_00_00_00_02;
        local_ip           = LOCAL_IP;
        gateway_ip         = GW_IP;
        subnet_mask        = 32'hFFFF_FF00;
        fork
            drive_ready_stalls();
        join_none
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reply_to_request();
        broadcast_lookups();
        learned_hits();
        miss_answered_late();
        miss_never_answered();
        clear_and_relookup();
        $display("checks: %0d, mismatches: %0d, other failures: %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* hdl/arp_top.sv */
// ARP engine top level
// plain ports, stage wiring, shared lookup response
`timescale 1ns/100ps

module arp_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_frame_valid,
    output logic                in_frame_ready,
    input  arp_pkg::mac_addr_t  in_eth_src_mac,
    input  logic [15:0]         in_eth_type,
    input  logic [15:0]         in_arp_htype,
    input  logic [15:0]         in_arp_ptype,
    input  arp_pkg::arp_oper_t  in_arp_oper,
    input  arp_pkg::mac_addr_t  in_arp_sha,
    input  arp_pkg::ip_addr_t   in_arp_spa,
    input  arp_pkg::mac_addr_t  in_arp_tha,
    input  arp_pkg::ip_addr_t   in_arp_tpa,
    output logic                out_frame_valid,
    input  logic                out_frame_ready,
    output arp_pkg::mac_addr_t  out_eth_dest_mac,
    output arp_pkg::arp_oper_t  out_arp_oper,
    output arp_pkg::mac_addr_t  out_arp_tha,
    output arp_pkg::ip_addr_t   out_arp_tpa,
    input  logic                arp_request_valid,
    output logic                arp_request_ready,
    input  arp_pkg::ip_addr_t   arp_request_ip,
    output logic                arp_response_valid,
    input  logic                arp_response_ready,
    output logic                arp_response_error,
    output arp_pkg::mac_addr_t  arp_response_mac,
    input  arp_pkg::mac_addr_t  local_mac,
    input  arp_pkg::ip_addr_t   local_ip,
    input  arp_pkg::ip_addr_t   gateway_ip,
    input  arp_pkg::ip_addr_t   subnet_mask,
    input  logic                clear_cache
);
    import arp_pkg::*;

    arp_frame_if   reply_if ();
    arp_frame_if   req_if ();
    cache_query_if query_if ();

    logic      wr_valid;
    ip_addr_t  wr_ip;
    mac_addr_t wr_mac;
    logic      tgt_valid;
    logic      tgt_ready;
    ip_addr_t  tgt_ip;
    logic      bcast_rsp_valid;
    logic      fsm_rsp_valid;
    logic      fsm_rsp_error;
    mac_addr_t fsm_rsp_mac;
    logic      lookup_busy;

    arp_rx_filter u_rx_filter (
        .clk, .rst_n, .in_frame_valid, .in_frame_ready,
        .in_eth_src_mac, .in_eth_type, .in_arp_htype, .in_arp_ptype, .in_arp_oper,
        .in_arp_sha, .in_arp_spa, .in_arp_tha, .in_arp_tpa, .local_ip,
        .wr_valid, .wr_ip, .wr_mac, .reply (reply_if.src)
    );

    arp_route_resolve u_route_resolve (
        .clk, .rst_n, .arp_request_valid, .arp_request_ready, .arp_request_ip,
        .gateway_ip, .subnet_mask, .tgt_valid, .tgt_ready, .tgt_ip,
        .bcast_rsp_valid, .arp_response_ready, .lookup_busy
    );

    arp_lookup_fsm u_lookup_fsm (
        .clk, .rst_n, .tgt_valid, .tgt_ready, .tgt_ip,
        .query (query_if.client), .req_frame (req_if.src),
        .rsp_valid (fsm_rsp_valid), .rsp_error (fsm_rsp_error), .rsp_mac (fsm_rsp_mac),
        .arp_response_ready, .lookup_busy
    );

    arp_cache u_cache (
        .clk, .rst_n, .query (query_if.server),
        .wr_valid, .wr_ip, .wr_mac, .clear_cache
    );

    arp_tx_select u_tx_select (
        .clk, .rst_n, .req_frame (req_if.dst), .reply (reply_if.dst),
        .out_frame_valid, .out_frame_ready,
        .out_eth_dest_mac, .out_arp_oper, .out_arp_tha, .out_arp_tpa
    );

    // resolver and FSM responses are mutually exclusive
    assign arp_response_valid = bcast_rsp_valid || fsm_rsp_valid;
    assign arp_response_error = fsm_rsp_valid && fsm_rsp_error;
    assign arp_response_mac   = bcast_rsp_valid ? MAC_BROADCAST : fsm_rsp_mac;

    a_rsp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(bcast_rsp_valid && fsm_rsp_valid));

endmodule

/* hdl/arp_tx_select.sv */
// output frame slot, request frames before replies
`timescale 1ns/100ps

module arp_tx_select (
    input  logic                clk,
    input  logic                rst_n,
    arp_frame_if.dst            req_frame,
    arp_frame_if.dst            reply,
    output logic                out_frame_valid,
    input  logic                out_frame_ready,
    output arp_pkg::mac_addr_t  out_eth_dest_mac,
    output arp_pkg::arp_oper_t  out_arp_oper,
    output arp_pkg::mac_addr_t  out_arp_tha,
    output arp_pkg::ip_addr_t   out_arp_tpa
);
    logic load;

    // slot empty or draining this cycle
    assign load = !out_frame_valid || out_frame_ready;

    assign req_frame.ready = load;
    assign reply.ready     = load && !req_frame.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_frame_valid <= 1'b0;
        end else if (load) begin
            out_frame_valid <= req_frame.valid || reply.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load && req_frame.valid) begin
            out_eth_dest_mac <= req_frame.eth_dest_mac;
            out_arp_oper     <= req_frame.arp_oper;
            out_arp_tha      <= req_frame.arp_tha;
            out_arp_tpa      <= req_frame.arp_tpa;
        end else if (load && reply.valid) begin
            out_eth_dest_mac <= reply.eth_dest_mac;
            out_arp_oper     <= reply.arp_oper;
            out_arp_tha      <= reply.arp_tha;
            out_arp_tpa      <= reply.arp_tpa;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_frame_valid && !out_frame_ready |=> out_frame_valid &&
        $stable(out_eth_dest_mac) && $stable(out_arp_oper) &&
        $stable(out_arp_tha) && $stable(out_arp_tpa));

endmodule

/* hdl/arp_cache.sv */
// direct-mapped IP to MAC cache with query, write and clear
`timescale 1ns/100ps

module arp_cache (
    input  logic                clk,
    input  logic                rst_n,
    cache_query_if.server       query,
    input  logic                wr_valid,
    input  arp_pkg::ip_addr_t   wr_ip,
    input  arp_pkg::mac_addr_t  wr_mac,
    input  logic                clear_cache
);
    import arp_pkg::*;

    logic [2**CACHE_ADDR_WIDTH-1:0] entry_valid;
    ip_addr_t   tag_mem [2**CACHE_ADDR_WIDTH];
    mac_addr_t  mac_mem [2**CACHE_ADDR_WIDTH];
    cache_idx_t rd_idx;
    cache_idx_t wr_idx;

    // low address bits index the table and the full IP is the tag
    assign rd_idx = query.req_ip[CACHE_ADDR_WIDTH-1:0];
    assign wr_idx = wr_ip[CACHE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n || clear_cache) begin
            entry_valid <= '0;
        end else if (wr_valid) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            tag_mem[wr_idx] <= wr_ip;
            mac_mem[wr_idx] <= wr_mac;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            query.rsp_valid <= 1'b0;
            query.rsp_error <= 1'b0;
        end else begin
            query.rsp_valid <= query.req_valid;
            query.rsp_error <= !(entry_valid[rd_idx] && tag_mem[rd_idx] == query.req_ip);
        end
    end

    always_ff @(posedge clk) begin
        query.rsp_mac <= mac_mem[rd_idx];
    end

    // a write is seen by a query of the same IP one cycle later
    a_wr_visible: assert property (@(posedge clk) disable iff (!rst_n)
        $past(wr_valid) && !$past(clear_cache) && query.req_valid &&
        query.req_ip == $past(wr_ip)
        |=> !query.rsp_error && query.rsp_mac == $past(wr_mac, 2));

endmodule

/* hdl/arp_lookup_fsm.sv */
// lookup FSM with cache query, request retries, timeout and response hold
`timescale 1ns/100ps

module arp_lookup_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                tgt_valid,
    output logic                tgt_ready,
    input  arp_pkg::ip_addr_t   tgt_ip,
    cache_query_if.client       query,
    arp_frame_if.src            req_frame,
    output logic                rsp_valid,
    output logic                rsp_error,
    output arp_pkg::mac_addr_t  rsp_mac,
    input  logic                arp_response_ready,
    output logic                lookup_busy
);
    import arp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_QUERY,
        ST_WAIT_REPLY,
        ST_RESPOND
    } state_t;

    state_t     state;
    state_t     state_next;
    ip_addr_t   ip_q;
    retry_cnt_t sent_cnt;
    timer_t     timer;
    logic       tgt_accept;
    logic       frame_done;
    logic       hit;
    logic       timer_fire;

    assign tgt_ready   = (state == ST_IDLE) && !req_frame.valid;
    assign tgt_accept  = tgt_valid && tgt_ready;
    assign frame_done  = req_frame.valid && req_frame.ready;
    assign hit         = query.rsp_valid && !query.rsp_error;
    // fires one cycle early since the frame valid is registered
    assign timer_fire  = !req_frame.valid && (timer == timer_t'(1));
    // a request frame still waiting on the output also blocks new lookups
    assign lookup_busy = (state != ST_IDLE) || req_frame.valid;
    assign rsp_valid   = state == ST_RESPOND;
    assign query.req_ip = ip_q;

    assign req_frame.eth_dest_mac = MAC_BROADCAST;
    assign req_frame.arp_oper     = ARP_OPER_REQUEST;
    assign req_frame.arp_tha      = '0;
    assign req_frame.arp_tpa      = ip_q;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (tgt_accept) state_next = ST_QUERY;
            end
            ST_QUERY: begin
                if (query.rsp_valid) state_next = hit ? ST_RESPOND : ST_WAIT_REPLY;
            end
            ST_WAIT_REPLY: begin
                if (hit || (timer_fire && sent_cnt == retry_cnt_t'(RETRY_COUNT))) begin
                    state_next = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (arp_response_ready) state_next = ST_IDLE;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            query.req_valid <= 1'b0;
            req_frame.valid <= 1'b0;
            sent_cnt        <= '0;
            timer           <= '0;
        end else begin
            state <= state_next;
            // one query per cycle for as long as the wait lasts
            query.req_valid <= tgt_accept || (state_next == ST_WAIT_REPLY);
            if (state == ST_QUERY && state_next == ST_WAIT_REPLY) begin
                req_frame.valid <= 1'b1;
                sent_cnt        <= '0;
            end else if (frame_done) begin
                req_frame.valid <= 1'b0;
                sent_cnt        <= sent_cnt + retry_cnt_t'(1);
                if (sent_cnt + retry_cnt_t'(1) == retry_cnt_t'(RETRY_COUNT)) begin
                    timer <= timer_t'(REQUEST_TIMEOUT - 1);
                end else begin
                    timer <= timer_t'(RETRY_INTERVAL - 1);
                end
            end else if (state == ST_WAIT_REPLY && !req_frame.valid) begin
                if (timer_fire && state_next == ST_WAIT_REPLY) begin
                    req_frame.valid <= 1'b1;
                end else if (timer != '0) begin
                    timer <= timer - timer_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_next == ST_RESPOND && state != ST_RESPOND) begin
            rsp_error <= !hit;
            rsp_mac   <= query.rsp_mac;
        end else if (tgt_accept) begin
            ip_q <= tgt_ip;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !arp_response_ready |=> rsp_valid);

endmodule

/* hdl/arp_route_resolve.sv */
// lookup routing: broadcast answers, on-subnet and gateway targets
`timescale 1ns/100ps

module arp_route_resolve (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               arp_request_valid,
    output logic               arp_request_ready,
    input  arp_pkg::ip_addr_t  arp_request_ip,
    input  arp_pkg::ip_addr_t  gateway_ip,
    input  arp_pkg::ip_addr_t  subnet_mask,
    output logic               tgt_valid,
    input  logic               tgt_ready,
    output arp_pkg::ip_addr_t  tgt_ip,
    output logic               bcast_rsp_valid,
    input  logic               arp_response_ready,
    input  logic               lookup_busy
);
    import arp_pkg::*;

    logic accept;
    logic on_subnet;
    logic is_bcast;

    assign accept = arp_request_valid && arp_request_ready;

    // no bits differ from the gateway where the mask is set
    assign on_subnet = ((arp_request_ip ^ gateway_ip) & subnet_mask) == '0;
    assign is_bcast  = (arp_request_ip == IP_BROADCAST) ||
                       (on_subnet && ((arp_request_ip | subnet_mask) == IP_BROADCAST));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arp_request_ready <= 1'b0;
            tgt_valid         <= 1'b0;
            bcast_rsp_valid   <= 1'b0;
        end else begin
            tgt_valid       <= (accept && !is_bcast) || (tgt_valid && !tgt_ready);
            bcast_rsp_valid <= (accept && is_bcast) || (bcast_rsp_valid && !arp_response_ready);
            // tgt_valid covers the handoff cycle before the FSM reports busy
            arp_request_ready <= !accept && !tgt_valid && !lookup_busy &&
                                 !(bcast_rsp_valid && !arp_response_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tgt_ip <= on_subnet ? arp_request_ip : gateway_ip;
        end
    end

endmodule

/* hdl/arp_rx_filter.sv */
// receive stage with header check, cache learning and reply generation
`timescale 1ns/100ps

module arp_rx_filter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_frame_valid,
    output logic                in_frame_ready,
    input  arp_pkg::mac_addr_t  in_eth_src_mac,
    input  logic [15:0]         in_eth_type,
    input  logic [15:0]         in_arp_htype,
    input  logic [15:0]         in_arp_ptype,
    input  arp_pkg::arp_oper_t  in_arp_oper,
    input  arp_pkg::mac_addr_t  in_arp_sha,
    input  arp_pkg::ip_addr_t   in_arp_spa,
    input  arp_pkg::mac_addr_t  in_arp_tha,
    input  arp_pkg::ip_addr_t   in_arp_tpa,
    input  arp_pkg::ip_addr_t   local_ip,
    output logic                wr_valid,
    output arp_pkg::ip_addr_t   wr_ip,
    output arp_pkg::mac_addr_t  wr_mac,
    arp_frame_if.src            reply
);
    import arp_pkg::*;

    logic accept;
    logic frame_ok;
    logic want_reply;
    logic reply_next;

    assign accept = in_frame_valid && in_frame_ready;

    // header fields must say Ethernet and IPv4
    assign frame_ok = (in_eth_type == ETH_TYPE_ARP) && (in_arp_htype == ARP_HTYPE_ETH) &&
                      (in_arp_ptype == ARP_PTYPE_IPV4);
    assign want_reply = frame_ok && (in_arp_oper == ARP_OPER_REQUEST) &&
                        (in_arp_tpa == local_ip);
    assign reply_next = (accept && want_reply) || (reply.valid && !reply.ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reply.valid    <= 1'b0;
            wr_valid       <= 1'b0;
            in_frame_ready <= 1'b0;
        end else begin
            reply.valid <= reply_next;
            wr_valid    <= accept && frame_ok;
            // low for a cycle after each frame and while a reply waits
            in_frame_ready <= !accept && !reply_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_ip  <= in_arp_spa;
            wr_mac <= in_arp_sha;
        end
        if (accept && want_reply) begin
            reply.eth_dest_mac <= in_eth_src_mac;
            reply.arp_oper     <= ARP_OPER_REPLY;
            reply.arp_tha      <= in_arp_sha;
            reply.arp_tpa      <= in_arp_spa;
        end
    end

    // cache sees at most one write every other cycle
    a_wr_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        wr_valid |=> !wr_valid);

endmodule

/* hdl/arp_ifs.sv */
// frame field interface and cache query interface
`timescale 1ns/100ps

interface arp_frame_if;
    import arp_pkg::*;

    logic      valid;
    logic      ready;
    mac_addr_t eth_dest_mac;
    arp_oper_t arp_oper;
    mac_addr_t arp_tha;
    ip_addr_t  arp_tpa;

    // source holds valid and fields until ready
    modport src (output valid, eth_dest_mac, arp_oper, arp_tha, arp_tpa, input ready);
    modport dst (input valid, eth_dest_mac, arp_oper, arp_tha, arp_tpa, output ready);
endinterface

interface cache_query_if;
    import arp_pkg::*;

    logic      req_valid;
    ip_addr_t  req_ip;
    logic      rsp_valid;
    logic      rsp_error;
    mac_addr_t rsp_mac;

    // response exactly one cycle after the request pulse
    modport client (output req_valid, req_ip, input rsp_valid, rsp_error, rsp_mac);
    modport server (input req_valid, req_ip, output rsp_valid, rsp_error, rsp_mac);
endinterface

/* hdl/arp_pkg.sv */
// ARP engine shared definitions
// address types, ARP field constants, cache sizing, retry timing
package arp_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] arp_oper_t;

    // header field values
    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;

    localparam arp_oper_t ARP_OPER_REQUEST = 16'h0001;
    localparam arp_oper_t ARP_OPER_REPLY   = 16'h0002;

    localparam mac_addr_t MAC_BROADCAST = '1;
    localparam ip_addr_t  IP_BROADCAST  = '1;

    // cache sizing
    localparam int CACHE_ADDR_WIDTH = 4;
    typedef logic [CACHE_ADDR_WIDTH-1:0] cache_idx_t;

    // request retries, short intervals for simulation
    localparam int RETRY_COUNT     = 4;
    localparam int RETRY_INTERVAL  = 64;
    localparam int REQUEST_TIMEOUT = 256;

    typedef logic [15:0] timer_t;
    typedef logic [2:0]  retry_cnt_t;

endpackage
